//--- rtl/femtoSettings.svh
// The reset address must be word aligned, and the address width must stay between 3 and 32
`ifndef FEMTO_SETTINGS_SVH
`define FEMTO_SETTINGS_SVH

// First fetch address after reset, full 32 bits
`define FEMTO_RESET_ADDR 32'h0000_0000

// Address bits kept inside the core
// Upper memory address bits are driven zero
`define FEMTO_ADDR_WIDTH 24

`endif

//--- rtl/rvIsaPkg.sv
// RV32I base types only, so opcodes of the M, F and SYSTEM groups have no enum value
package rvIsaPkg;

   // Data word, registers and memory bus
   typedef logic [31:0] word_t;

   // Latched instruction, the two low bits are always 2'b11 in RV32I
   typedef logic [31:2] instr_t;

   // Register index for rd, rs1, rs2
   typedef logic [4:0] regIdx_t;

   // funct3 in one-hot form, bit n set when funct3 == n
   typedef logic [7:0] funct3Hot_t;

   // Opcode groups on instruction bits 6 to 2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcode_e;

endpackage

//--- rtl/corePkg.sv
// Address width follows FEMTO_ADDR_WIDTH, and the state encoding is strictly one-hot
`include "femtoSettings.svh"

package corePkg;

   // Address as held in the PC and the load/store adder
   typedef logic [`FEMTO_ADDR_WIDTH-1:0] addr_t;

   // One state bit per step of the instruction cycle
   typedef enum logic [4:0] {
      fetchInstr = 5'b00001,
      waitInstr  = 5'b00010,
      execute1   = 5'b00100,
      execute2   = 5'b01000,
      waitMem    = 5'b10000
   } coreState_e;

endpackage

//--- rtl/coreControl.sv
// Every load and store waits in waitMem, and nothing else waits there
`timescale 1ns/1ns

module coreControl (
   input  logic                clk,
   input  logic                reset,
   input  logic                memRbusy,
   input  logic                memWbusy,
   input  logic                needsMem,
   output corePkg::coreState_e state
);

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for any write still pending in memory
         state <= corePkg::waitMem;
      end else begin
         case (state)
            corePkg::fetchInstr: begin
               // Read strobe goes out in this cycle
               state <= corePkg::waitInstr;
            end
            corePkg::waitInstr: begin
               // Hold until the instruction word is valid
               if (!memRbusy) begin
                  state <= corePkg::execute1;
               end
            end
            corePkg::execute1: begin
               state <= corePkg::execute2;
            end
            corePkg::execute2: begin
               // Memory access starts here for loads and stores
               state <= needsMem ? corePkg::waitMem : corePkg::fetchInstr;
            end
            corePkg::waitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= corePkg::fetchInstr;
               end
            end
            default: begin
               // Illegal encoding, resync through the wait state
               state <= corePkg::waitMem;
            end
         endcase
      end
   end

   // Exactly one state bit set whenever out of reset
   stateOneHot: assert property (@(posedge clk) disable iff (!reset)
      $onehot(state));

   // Execute phases never get split by a stall
   execute1ThenExecute2: assert property (@(posedge clk) disable iff (!reset)
      state == corePkg::execute1 |=> state == corePkg::execute2);

endmodule

//--- rtl/instrDecode.sv
// Only the nine RV32I opcode groups raise a flag, so unknown opcodes retire as no-ops
`timescale 1ns/1ns

module instrDecode (
   input  logic                   clk,
   input  logic                   latch,
   input  rvIsaPkg::word_t        memRdata,
   output rvIsaPkg::instr_t       instr,
   output rvIsaPkg::funct3Hot_t   funct3Hot,
   output logic                   isLoad,
   output logic                   isAluImm,
   output logic                   isAuipc,
   output logic                   isStore,
   output logic                   isAluReg,
   output logic                   isLui,
   output logic                   isBranch,
   output logic                   isJalr,
   output logic                   isJal,
   output rvIsaPkg::regIdx_t      rdId,
   output rvIsaPkg::word_t        immI,
   output rvIsaPkg::word_t        immS,
   output rvIsaPkg::word_t        immB,
   output rvIsaPkg::word_t        immU,
   output rvIsaPkg::word_t        immJ
);

   rvIsaPkg::opcode_e opcode;

   // Opcode field of the word on the bus
   assign opcode = rvIsaPkg::opcode_e'(memRdata[6:2]);

   always_ff @(posedge clk) begin
      if (latch) begin
         isLoad    <= (opcode == rvIsaPkg::opLoad);
         isAluImm  <= (opcode == rvIsaPkg::opAluImm);
         isAuipc   <= (opcode == rvIsaPkg::opAuipc);
         isStore   <= (opcode == rvIsaPkg::opStore);
         isAluReg  <= (opcode == rvIsaPkg::opAluReg);
         isLui     <= (opcode == rvIsaPkg::opLui);
         isBranch  <= (opcode == rvIsaPkg::opBranch);
         isJalr    <= (opcode == rvIsaPkg::opJalr);
         isJal     <= (opcode == rvIsaPkg::opJal);
         // One-hot funct3 keeps the ALU mux flat
         funct3Hot <= 8'b0000_0001 << memRdata[14:12];
         instr     <= memRdata[31:2];
      end
   end

   assign rdId = instr[11:7];

   // Immediate formats, all sign extended from bit 31
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

//--- rtl/regFile.sv
// Reads happen only on latch, so a write in execute2 is seen by the next instruction only
`timescale 1ns/1ns

module regFile (
   input  logic              clk,
   input  logic              reset,
   input  logic              latch,
   input  rvIsaPkg::regIdx_t rs1Id,
   input  rvIsaPkg::regIdx_t rs2Id,
   input  logic              writeEn,
   input  rvIsaPkg::regIdx_t rdId,
   input  rvIsaPkg::word_t   writeData,
   output rvIsaPkg::word_t   rs1,
   output rvIsaPkg::word_t   rs2
);

   rvIsaPkg::word_t regs [32];

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Cleared storage, x0 stays zero since it is never written
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && rdId != 5'd0) begin
         regs[rdId] <= writeData;
      end
   end

   // Source operands captured with the instruction word
   always_ff @(posedge clk) begin
      if (latch) begin
         rs1 <= regs[rs1Id];
         rs2 <= regs[rs2Id];
      end
   end

endmodule

//--- rtl/aluUnit.sv
// Result and predicate hold from execute1 on, and shifts use only the five low operand bits
`timescale 1ns/1ns

module aluUnit (
   input  logic                 clk,
   input  logic                 execute1,
   input  rvIsaPkg::instr_t     instr,
   input  rvIsaPkg::funct3Hot_t funct3Hot,
   input  logic                 isAluReg,
   input  logic                 isBranch,
   input  rvIsaPkg::word_t      rs1,
   input  rvIsaPkg::word_t      rs2,
   input  rvIsaPkg::word_t      immI,
   output rvIsaPkg::word_t      aluOut,
   output rvIsaPkg::word_t      aluSum,
   output logic                 predicate
);

   // Bit reversal, lets the right shifter also do left shifts
   function automatic rvIsaPkg::word_t flip32(input rvIsaPkg::word_t x);
      rvIsaPkg::word_t y;
      for (int i = 0; i < 32; i++) begin
         y[i] = x[31 - i];
      end
      return y;
   endfunction

   rvIsaPkg::word_t aluIn2;
   logic [32:0]     aluMinus;
   logic            lt;
   logic            ltu;
   logic            eq;
   rvIsaPkg::word_t shiftIn;
   logic [32:0]     shiftFull;
   rvIsaPkg::word_t shiftRight;
   rvIsaPkg::word_t shiftLeft;
   rvIsaPkg::word_t aluResult;
   logic            predicateNow;

   // rs2 for register ops and branches, I immediate for the rest
   assign aluIn2 = (isAluReg || isBranch) ? rs2 : immI;

   // Also the JALR target
   assign aluSum = rs1 + aluIn2;

   // Single 33-bit subtract serves SUB and every compare
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   // SLL flips in and out, SRA extends with bit 31 when instr[30] set
   assign shiftIn    = funct3Hot[1] ? flip32(rs1) : rs1;
   assign shiftFull  = $signed({instr[30] & rs1[31], shiftIn}) >>> aluIn2[4:0];
   assign shiftRight = shiftFull[31:0];
   assign shiftLeft  = flip32(shiftRight);

   // SUB needs instr[5] too, ADDI reuses bit 30 for its immediate
   assign aluResult =
      (funct3Hot[0] ? ((instr[30] & instr[5]) ? aluMinus[31:0] : aluSum) : 32'd0) |
      (funct3Hot[1] ? shiftLeft       : 32'd0) |
      (funct3Hot[2] ? {31'd0, lt}     : 32'd0) |
      (funct3Hot[3] ? {31'd0, ltu}    : 32'd0) |
      (funct3Hot[4] ? rs1 ^ aluIn2    : 32'd0) |
      (funct3Hot[5] ? shiftRight      : 32'd0) |
      (funct3Hot[6] ? rs1 | aluIn2    : 32'd0) |
      (funct3Hot[7] ? rs1 & aluIn2    : 32'd0);

   // BEQ BNE BLT BGE BLTU BGEU
   assign predicateNow =
      funct3Hot[0] &  eq  |
      funct3Hot[1] & ~eq  |
      funct3Hot[4] &  lt  |
      funct3Hot[5] & ~lt  |
      funct3Hot[6] &  ltu |
      funct3Hot[7] & ~ltu;

   always_ff @(posedge clk) begin
      if (execute1) begin
         aluOut    <= aluResult;
         // Taken only for real branches
         predicate <= isBranch & predicateNow;
      end
   end

   // Decode must hand over exactly one funct3 bit
   funct3IsOneHot: assert property (@(posedge clk) execute1 |-> $onehot(funct3Hot));

endmodule

//--- rtl/pcUnit.sv
// Only FEMTO_ADDR_WIDTH address bits are kept, so targets wrap inside that space
`timescale 1ns/1ns
`include "femtoSettings.svh"

module pcUnit (
   input  logic            clk,
   input  logic            reset,
   input  logic            execute1,
   input  logic            execute2,
   input  logic            isJal,
   input  logic            isJalr,
   input  logic            isAuipc,
   input  logic            isStore,
   input  logic            predicate,
   input  rvIsaPkg::word_t rs1,
   input  rvIsaPkg::word_t immI,
   input  rvIsaPkg::word_t immS,
   input  rvIsaPkg::word_t immB,
   input  rvIsaPkg::word_t immU,
   input  rvIsaPkg::word_t immJ,
   input  rvIsaPkg::word_t aluSum,
   output corePkg::addr_t  pc,
   output corePkg::addr_t  pcPlus4,
   output corePkg::addr_t  pcPlusImm,
   output corePkg::addr_t  lsAddr
);

   localparam logic [31:0] resetAddr = `FEMTO_RESET_ADDR;

   assign pcPlus4 = pc + corePkg::addr_t'(4);

   // Target adders, loaded once per instruction
   always_ff @(posedge clk) begin
      if (execute1) begin
         // JAL, AUIPC, else branch offset
         pcPlusImm <= pc + (isJal   ? immJ[`FEMTO_ADDR_WIDTH-1:0] :
                            isAuipc ? immU[`FEMTO_ADDR_WIDTH-1:0] :
                                      immB[`FEMTO_ADDR_WIDTH-1:0]);
         lsAddr    <= rs1[`FEMTO_ADDR_WIDTH-1:0] +
                      (isStore ? immS[`FEMTO_ADDR_WIDTH-1:0] : immI[`FEMTO_ADDR_WIDTH-1:0]);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         pc <= resetAddr[`FEMTO_ADDR_WIDTH-1:0];
      end else if (execute2) begin
         // JALR clears bit 0, predicate is zero for non-branches
         pc <= isJalr              ? {aluSum[`FEMTO_ADDR_WIDTH-1:1], 1'b0} :
               (isJal | predicate) ? pcPlusImm :
                                     pcPlus4;
      end
   end

endmodule

//--- rtl/loadStoreUnit.sv
// Accesses are assumed naturally aligned; misaligned ones are neither split nor trapped
`timescale 1ns/1ns

module loadStoreUnit (
   input  rvIsaPkg::instr_t instr,
   input  logic [1:0]       lsAddrLow,
   input  rvIsaPkg::word_t  rs2,
   input  rvIsaPkg::word_t  memRdata,
   output rvIsaPkg::word_t  storeData,
   output logic [3:0]       storeMask,
   output rvIsaPkg::word_t  loadData
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // funct3[1:0] gives the size, 00 byte, 01 half, 10 word
   assign byteAccess = (instr[13:12] == 2'b00);
   assign halfAccess = (instr[13:12] == 2'b01);

   // Replicated lanes, the mask picks the live one
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddrLow[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddrLow[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddrLow[0] ? rs2[7:0] :
                             lsAddrLow[1] ? rs2[15:8] : rs2[31:24];

   assign storeMask = byteAccess ? (4'b0001 << lsAddrLow) :
                      halfAccess ? (lsAddrLow[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

   // Lane selection on the returned word
   assign loadHalf = lsAddrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU or LHU
   assign loadSign = ~instr[14] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

endmodule

//--- rtl/femtoCore.sv
// Single memory port for code and data, and one instruction in flight at a time
`timescale 1ns/1ns
`include "femtoSettings.svh"

module femtoCore (
   input  logic            clk,
   input  logic            reset,
   output rvIsaPkg::word_t memAddr,
   output rvIsaPkg::word_t memWdata,
   output logic [3:0]      memWmask,
   input  rvIsaPkg::word_t memRdata,
   output logic            memRstrb,
   input  logic            memRbusy,
   input  logic            memWbusy
);

   localparam int padWidth = 32 - `FEMTO_ADDR_WIDTH;

   corePkg::coreState_e  state;
   logic                 latch;
   logic                 execute1;
   logic                 execute2;
   rvIsaPkg::instr_t     instr;
   rvIsaPkg::funct3Hot_t funct3Hot;
   logic                 isLoad;
   logic                 isAluImm;
   logic                 isAuipc;
   logic                 isStore;
   logic                 isAluReg;
   logic                 isLui;
   logic                 isBranch;
   logic                 isJalr;
   logic                 isJal;
   rvIsaPkg::regIdx_t    rdId;
   rvIsaPkg::word_t      immI;
   rvIsaPkg::word_t      immS;
   rvIsaPkg::word_t      immB;
   rvIsaPkg::word_t      immU;
   rvIsaPkg::word_t      immJ;
   rvIsaPkg::word_t      rs1;
   rvIsaPkg::word_t      rs2;
   rvIsaPkg::word_t      aluOut;
   rvIsaPkg::word_t      aluSum;
   logic                 predicate;
   corePkg::addr_t       pc;
   corePkg::addr_t       pcPlus4;
   corePkg::addr_t       pcPlusImm;
   corePkg::addr_t       lsAddr;
   rvIsaPkg::word_t      storeData;
   logic [3:0]           storeMask;
   rvIsaPkg::word_t      loadData;
   logic                 writeEn;
   rvIsaPkg::word_t      writeData;

   // Strobes from the one-hot state
   assign latch    = (state == corePkg::waitInstr) & ~memRbusy;
   assign execute1 = (state == corePkg::execute1);
   assign execute2 = (state == corePkg::execute2);

   coreControl control (.clk, .reset, .memRbusy, .memWbusy,
      .needsMem(isLoad | isStore), .state);

   instrDecode decode (.clk, .latch, .memRdata, .instr, .funct3Hot,
      .isLoad, .isAluImm, .isAuipc, .isStore, .isAluReg, .isLui, .isBranch,
      .isJalr, .isJal, .rdId, .immI, .immS, .immB, .immU, .immJ);

   // Source indices straight from the fetched word
   regFile regs (.clk, .reset, .latch, .rs1Id(memRdata[19:15]),
      .rs2Id(memRdata[24:20]), .writeEn, .rdId, .writeData, .rs1, .rs2);

   aluUnit alu (.clk, .execute1, .instr, .funct3Hot, .isAluReg, .isBranch,
      .rs1, .rs2, .immI, .aluOut, .aluSum, .predicate);

   pcUnit pcu (.clk, .reset, .execute1, .execute2, .isJal, .isJalr, .isAuipc,
      .isStore, .predicate, .rs1, .immI, .immS, .immB, .immU, .immJ, .aluSum,
      .pc, .pcPlus4, .pcPlusImm, .lsAddr);

   loadStoreUnit lsu (.instr, .lsAddrLow(lsAddr[1:0]), .rs2, .memRdata,
      .storeData, .storeMask, .loadData);

   // Results in execute2, load data while in waitMem
   assign writeEn =
      execute2 & (isAluImm | isAluReg | isLui | isAuipc | isJal | isJalr) |
      (state == corePkg::waitMem) & isLoad;

   assign writeData =
      (isLui                  ? immU                            : 32'd0) |
      ((isAluImm | isAluReg)  ? aluOut                          : 32'd0) |
      (isAuipc                ? {{padWidth{1'b0}}, pcPlusImm}   : 32'd0) |
      ((isJal | isJalr)       ? {{padWidth{1'b0}}, pcPlus4}     : 32'd0) |
      (isLoad                 ? loadData                        : 32'd0);

   // PC while fetching, data address otherwise
   assign memAddr = {{padWidth{1'b0}},
      (state == corePkg::fetchInstr || state == corePkg::waitInstr) ? pc : lsAddr};

   assign memRstrb = (state == corePkg::fetchInstr) | execute2 & isLoad;
   assign memWmask = {4{execute2 & isStore}} & storeMask;
   assign memWdata = storeData;

endmodule

//--- verification/tbClock.sv
// Free running clock with a 4 ns period, starting low at time zero
`timescale 1ns/1ns

module tbClock (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // Half period of 2 ns
   always #2 clk = ~clk;

endmodule

//--- verification/femtoCoreTb.sv
// Memory model covers 2 KiB only, so the program, results and markers must stay below 0x800
`timescale 1ns/1ns
`include "femtoSettings.svh"

module femtoCoreTb;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] mem [512];
   logic [31:0] expAddr [$];
   logic [3:0]  expMask [$];
   logic [31:0] expData [$];
   logic [31:0] progPc;
   logic [31:0] resOff;
   logic [31:0] markerOff;
   logic [31:0] linkPc;
   logic [31:0] wordA;
   logic [31:0] wordB;
   logic [31:0] word0;
   logic [31:0] word4;
   logic [31:0] byteLanes;
   logic        seenStrobe;
   int          cycles;
   int          cycleLimit;

   tbClock clockGen (.clk);

   femtoCore uut (.clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
      .memRstrb, .memRbusy, .memWbusy);

   // RV32I encoders for each instruction format
   function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   // Load result from a known word by offset, size and signedness
   function automatic logic [31:0] extendLoad(logic [31:0] w, int off, int size, bit sgn);
      logic [31:0] v;
      v = w >> (8 * off);
      if (size == 1) begin
         v = sgn ? {{24{v[7]}}, v[7:0]} : {24'd0, v[7:0]};
      end else if (size == 2) begin
         v = sgn ? {{16{v[15]}}, v[15:0]} : {16'd0, v[15:0]};
      end
      return v;
   endfunction

   // Byte mask widened to a bit mask
   function automatic logic [31:0] laneBits(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic put(logic [31:0] instrWord);
      mem[progPc[10:2]] = instrWord;
      progPc = progPc + 4;
   endtask

   task automatic expectStore(logic [31:0] addr, logic [3:0] mask, logic [31:0] data);
      expAddr.push_back(addr);
      expMask.push_back(mask);
      expData.push_back(data);
   endtask

   // sw rs to the next result slot at 0x400 and expect that word
   task automatic storeResult(logic [4:0] rs, logic [31:0] value);
      put(encS(resOff[11:0], rs, 5'd10, 3'd2));
      expectStore(32'h400 + resOff, 4'hF, value);
      resOff = resOff + 4;
   endtask

   task automatic aluCheck(logic [31:0] instrWord, logic [31:0] value);
      put(instrWord);
      storeResult(5'd3, value);
   endtask

   task automatic loadCheck(int off, logic [2:0] f3, logic [31:0] value);
      put(encI(off[11:0], 5'd11, f3, 5'd4, 7'h03));
      storeResult(5'd4, value);
   endtask

   // Branch over a marker store, which lands only when not taken
   task automatic branchCheck(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, bit taken);
      put(encB(13'd8, rs2, rs1, f3));
      put(encS(markerOff[11:0], 5'd5, 5'd12, 3'd2));
      if (!taken) begin
         expectStore(32'h700 + markerOff, 4'hF, 32'h55);
      end
      markerOff = markerOff + 4;
   endtask

   task automatic stopOnFailure();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   initial begin
      void'($urandom(32'h2253_5359));
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      seenStrobe = 1'b0;
      cycles = 0;
      progPc = `FEMTO_RESET_ADDR;
      resOff = 0;
      markerOff = 0;
      wordA = 32'h1234_5678;
      wordB = 32'hFFFF_FFFD;
      // Fill pattern mixes every address bit
      for (int i = 0; i < 512; i++) begin
         mem[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0101);
      end
      // Operands, result base, data base, marker base
      put({20'h12345, 5'd1, 7'h37});
      put(encI(12'h678, 5'd1, 3'd0, 5'd1, 7'h13));
      put(encI(-12'sd3, 5'd0, 3'd0, 5'd2, 7'h13));
      put(encI(12'h400, 5'd0, 3'd0, 5'd10, 7'h13));
      put(encI(12'h600, 5'd0, 3'd0, 5'd11, 7'h13));
      put(encI(12'h700, 5'd0, 3'd0, 5'd12, 7'h13));
      put(encI(12'h055, 5'd0, 3'd0, 5'd5, 7'h13));
      aluCheck(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), wordA + wordB);
      aluCheck(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), wordA - wordB);
      aluCheck(encR(7'h00, 5'd1, 5'd2, 3'd2, 5'd3), 32'd1);
      aluCheck(encR(7'h00, 5'd1, 5'd2, 3'd3, 5'd3), 32'd0);
      aluCheck(encR(7'h00, 5'd1, 5'd2, 3'd1, 5'd3), wordB << wordA[4:0]);
      aluCheck(encR(7'h00, 5'd1, 5'd2, 3'd5, 5'd3), wordB >> wordA[4:0]);
      aluCheck(encR(7'h20, 5'd1, 5'd2, 3'd5, 5'd3), $signed(wordB) >>> wordA[4:0]);
      aluCheck(encR(7'h00, 5'd2, 5'd1, 3'd4, 5'd3), wordA ^ wordB);
      aluCheck(encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd3), wordA | wordB);
      aluCheck(encR(7'h00, 5'd2, 5'd1, 3'd7, 5'd3), wordA & wordB);
      aluCheck(encI(-12'sd2, 5'd2, 3'd2, 5'd3, 7'h13), 32'd1);
      aluCheck(encI(-12'sd1, 5'd1, 3'd3, 5'd3, 7'h13), 32'd1);
      aluCheck(encI(12'h004, 5'd1, 3'd1, 5'd3, 7'h13), wordA << 4);
      aluCheck(encI(12'h404, 5'd2, 3'd5, 5'd3, 7'h13), $signed(wordB) >>> 4);
      aluCheck(encI(12'h0FF, 5'd1, 3'd4, 5'd3, 7'h13), wordA ^ 32'hFF);
      aluCheck({20'hABCDE, 5'd3, 7'h37}, 32'hABCD_E000);
      aluCheck({20'h00001, 5'd3, 7'h17}, progPc + 32'h1000);
      // Word, halfword and byte stores at every offset
      put(encS(12'd0, 5'd1, 5'd11, 3'd2));
      expectStore(32'h600, 4'hF, wordA);
      put(encS(12'd2, 5'd2, 5'd11, 3'd1));
      expectStore(32'h602, 4'b1100, {2{wordB[15:0]}});
      for (int off = 0; off < 4; off++) begin
         byteLanes = (off % 2 == 0) ? {4{wordA[7:0]}} : {4{wordB[7:0]}};
         put(encS(12'd4 + off[11:0], (off % 2 == 0) ? 5'd1 : 5'd2, 5'd11, 3'd0));
         expectStore(32'h604 + off, 4'b0001 << off, byteLanes);
      end
      put(encS(12'd8, 5'd1, 5'd11, 3'd1));
      expectStore(32'h608, 4'b0011, {2{wordA[15:0]}});
      word0 = {wordB[15:0], wordA[15:0]};
      word4 = {wordB[7:0], wordA[7:0], wordB[7:0], wordA[7:0]};
      // Loads of the words just written
      loadCheck(1, 3'd0, extendLoad(word0, 1, 1, 1));
      loadCheck(3, 3'd0, extendLoad(word0, 3, 1, 1));
      loadCheck(2, 3'd4, extendLoad(word0, 2, 1, 0));
      loadCheck(2, 3'd1, extendLoad(word0, 2, 2, 1));
      loadCheck(2, 3'd5, extendLoad(word0, 2, 2, 0));
      loadCheck(0, 3'd2, word0);
      loadCheck(5, 3'd0, extendLoad(word4, 1, 1, 1));
      loadCheck(4, 3'd4, extendLoad(word4, 0, 1, 0));
      loadCheck(6, 3'd1, extendLoad(word4, 2, 2, 1));
      loadCheck(8, 3'd5, {16'd0, wordA[15:0]});
      // x1 is positive and x2 negative
      branchCheck(3'd0, 5'd1, 5'd1, 1'b1);
      branchCheck(3'd1, 5'd1, 5'd2, 1'b1);
      branchCheck(3'd1, 5'd1, 5'd1, 1'b0);
      branchCheck(3'd4, 5'd2, 5'd1, 1'b1);
      branchCheck(3'd5, 5'd2, 5'd1, 1'b0);
      branchCheck(3'd6, 5'd1, 5'd2, 1'b1);
      branchCheck(3'd7, 5'd1, 5'd2, 1'b0);
      // JAL over a marker and then its link
      linkPc = progPc;
      put(encJ(21'd8, 5'd6));
      put(encS(markerOff[11:0], 5'd5, 5'd12, 3'd2));
      markerOff = markerOff + 4;
      storeResult(5'd6, linkPc + 4);
      // JALR with an odd offset drops bit 0 of the target
      linkPc = progPc;
      put({20'h00000, 5'd7, 7'h17});
      put(encI(12'd13, 5'd7, 3'd0, 5'd6, 7'h67));
      put(encS(markerOff[11:0], 5'd5, 5'd12, 3'd2));
      storeResult(5'd6, linkPc + 8);
      // Final store ends the run and the core then spins
      put(encS(12'h0FC, 5'd5, 5'd12, 3'd2));
      expectStore(32'h7FC, 4'hF, 32'h55);
      put(encJ(21'd0, 5'd0));
      cycleLimit = 40 * (progPc / 4);
      repeat (10) @(posedge clk);
      #1 reset = 1'b1;
   end

   // Read captured on the strobe, busy random, all driven 1 ns after the edge
   always @(posedge clk) begin
      if (memRstrb) begin
         memRdata <= #1 mem[memAddr[10:2]];
      end
      memRbusy <= #1 reset && ($urandom % 3 == 0);
      memWbusy <= #1 reset && ($urandom % 3 == 0);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycleLimit && reset) begin
         $display("Timeout: the final store was not reached in %0d cycles", cycleLimit);
         stopOnFailure();
      end
      if (reset && memRstrb) begin
         seenStrobe <= 1'b1;
      end
      if (reset && memWmask != 4'd0) begin
         assert (memAddr == expAddr[0]) else begin
            $display("[ERROR] %0t memAddr expected %h got %h", $time, expAddr[0], memAddr);
            stopOnFailure();
         end
         assert (memWmask == expMask[0]) else begin
            $display("[ERROR] %0t memWmask expected %b got %b", $time, expMask[0],
                     memWmask);
            stopOnFailure();
         end
         // Only the live lanes carry defined data
         assert ((memWdata & laneBits(expMask[0])) == (expData[0] & laneBits(expMask[0])))
         else begin
            $display("[ERROR] %0t memWdata expected %h got %h", $time,
                     expData[0] & laneBits(expMask[0]), memWdata & laneBits(expMask[0]));
            stopOnFailure();
         end
         for (int i = 0; i < 4; i++) begin
            if (memWmask[i]) begin
               mem[memAddr[10:2]][8*i +: 8] <= memWdata[8*i +: 8];
            end
         end
         void'(expAddr.pop_front());
         void'(expMask.pop_front());
         void'(expData.pop_front());
         if (expAddr.size() == 0) begin
            $display("TEST PASSED");
            $finish;
         end
      end
   end

   // No write before the first fetch, which starts at the reset address
   firstFetchAddr: assert property (@(posedge clk) disable iff (!reset)
      (memRstrb && !seenStrobe) |-> memAddr == `FEMTO_RESET_ADDR)
   else begin
      $display("[ERROR] %0t memAddr expected %h got %h", $time, `FEMTO_RESET_ADDR,
               $sampled(memAddr));
      stopOnFailure();
   end

   noWriteBeforeFetch: assert property (@(posedge clk) disable iff (!reset)
      !seenStrobe |-> memWmask == 4'd0)
   else begin
      $display("[ERROR] %0t memWmask expected 0000 got %b", $time, $sampled(memWmask));
      stopOnFailure();
   end

   // Each store shows up exactly once whatever memWbusy does
   maskOneCycle: assert property (@(posedge clk) disable iff (!reset)
      memWmask != 4'd0 |=> memWmask == 4'd0)
   else begin
      $display("[ERROR] %0t memWmask expected 0000 got %b", $time, $sampled(memWmask));
      stopOnFailure();
   end

endmodule

//--- femtoCore.f
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/corePkg.sv
rtl/coreControl.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/pcUnit.sv
rtl/loadStoreUnit.sv
rtl/femtoCore.sv
verification/tbClock.sv
verification/femtoCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the femtoCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   -f femtoCore.f --top-module femtoCoreTb -o femtoCoreSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/femtoCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
   exit 0
fi
exit 1
